//--- exec_stage.sv
/*
 * Execute stage with ALU, write-back and the registered result port.
 * Tracks output credits and raises o_stall when a writing instruction has none left.
 * The combinational ALU result doubles as the forward bundle for decode.
 */
`timescale 1ns/10ps
`default_nettype none

module exec_stage
    import rv_exec_pkg::*;
(
    input  wire      clk,
    input  wire      i_rst,
    input  id_ex_t   i_id_ex,
    input  wire      i_res_credit,  // Consumer drained one result
    output logic     o_stall,
    output logic     o_fwd_en,
    output reg_idx_t o_fwd_rd,
    output word_t    o_fwd_value,
    output logic     o_wr_en,
    output reg_idx_t o_wr_idx,
    output word_t    o_wr_data,
    output result_t  o_result
);

    word_t       op_a;
    word_t       op_b;
    word_t       alu_res;
    logic        writing;    // Valid instruction with a destination
    logic        fire;       // Result leaves this cycle
    credit_cnt_t credits;
    logic        res_valid;
    word_t       res_pc;
    reg_idx_t    res_rd;
    word_t       res_value;

    assign op_a = i_id_ex.use_pc  ? i_id_ex.pc  : i_id_ex.rs1_data;
    assign op_b = i_id_ex.use_imm ? i_id_ex.imm : i_id_ex.rs2_data;

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = word_t'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;               // LUI
            ALU_LINK:   alu_res = i_id_ex.pc_next;    // JAL
            default:    alu_res = '0;
        endcase
    end

    assign writing = i_id_ex.valid && i_id_ex.wr_en;
    assign o_stall = writing && (credits == '0);  // Consumer buffer full
    assign fire    = writing && !o_stall;

    // Forward follows EX contents, stall or not
    assign o_fwd_en    = writing;
    assign o_fwd_rd    = i_id_ex.rd;
    assign o_fwd_value = alu_res;

    assign o_wr_en   = fire;
    assign o_wr_idx  = i_id_ex.rd;
    assign o_wr_data = alu_res;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            res_valid <= 1'b0;
            credits   <= credit_cnt_t'(OUT_CREDITS);
        end else begin
            res_valid <= fire;  // One-cycle pulse per result
            case ({fire, i_res_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // Spend and return cancel
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_pc    <= i_id_ex.pc;
            res_rd    <= i_id_ex.rd;
            res_value <= alu_res;
        end
    end

    assign o_result = '{valid: res_valid, pc: res_pc, rd: res_rd, value: res_value};

    // Underflow would wrap to 7, so one bound covers both ends
    a_credit_bound: assert property (@(posedge clk) disable iff (i_rst)
        credits <= credit_cnt_t'(OUT_CREDITS));

    // Consumer returns only what it was given
    a_credit_return: assert property (@(posedge clk) disable iff (i_rst)
        i_res_credit |-> (credits != credit_cnt_t'(OUT_CREDITS)) || fire);

endmodule

`default_nettype wire

//--- id_ex_reg.sv
/*
 * Pipeline register between decode and execute.
 * Loads the whole decoded bundle while i_en is high and holds it otherwise.
 * Synchronous reset clears every field, so EX starts on a bubble.
 */
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg
    import rv_exec_pkg::*;
(
    input  wire    clk,
    input  wire    i_rst,
    input  wire    i_en,      // Pipeline advance, low on stall
    input  id_ex_t i_id_ex,
    output id_ex_t o_id_ex
);

    id_ex_t id_ex_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            id_ex_q <= '0;
        end else if (i_en) begin
            id_ex_q <= i_id_ex;  // Bubble when the queue was empty
        end
    end

    assign o_id_ex = id_ex_q;

    // Stall only ever freezes a valid writing instruction, never a bubble
    a_stall_on_valid: assert property (@(posedge clk) disable iff (i_rst)
        !i_en |-> (id_ex_q.valid && id_ex_q.wr_en));

endmodule

`default_nettype wire

//--- instr_decoder.sv
/*
 * Combinational decode of the queue head into the next ID/EX bundle.
 * Drives the register file read indices and picks up the EX result as a forward.
 * Opcodes outside the supported set pass through as no-ops with wr_en low.
 */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder
    import rv_exec_pkg::*;
(
    input  fetch_pkt_t i_head,
    output reg_idx_t   o_rs1_idx,
    output reg_idx_t   o_rs2_idx,
    input  word_t      i_rs1_data,
    input  word_t      i_rs2_data,
    input  wire        i_fwd_en,     // EX holds a writing instruction
    input  reg_idx_t   i_fwd_rd,
    input  word_t      i_fwd_value,
    output id_ex_t     o_id_ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;        // funct7[5], SUB and SRA select
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_j;
    word_t      rs1_val;
    word_t      rs2_val;

    // funct3 table shared by OP and OP-IMM
    function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic sel_alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = sel_alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = sel_alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode    = i_head.instr[6:0];
    assign rd        = i_head.instr[11:7];
    assign funct3    = i_head.instr[14:12];
    assign o_rs1_idx = i_head.instr[19:15];
    assign o_rs2_idx = i_head.instr[24:20];
    assign alt       = i_head.instr[30];

    assign imm_i = {{20{i_head.instr[31]}}, i_head.instr[31:20]};
    assign imm_u = {i_head.instr[31:12], 12'b0};
    assign imm_j = {{12{i_head.instr[31]}}, i_head.instr[19:12], i_head.instr[20],
                    i_head.instr[30:21], 1'b0};

    // EX result lands in the file at this same edge, so take it from EX directly
    assign rs1_val = (i_fwd_en && (i_fwd_rd == o_rs1_idx) && (o_rs1_idx != '0))
                   ? i_fwd_value : i_rs1_data;
    assign rs2_val = (i_fwd_en && (i_fwd_rd == o_rs2_idx) && (o_rs2_idx != '0))
                   ? i_fwd_value : i_rs2_data;

    always_comb begin
        o_id_ex          = '0;
        o_id_ex.valid    = i_head.valid;
        o_id_ex.alu_op   = ALU_ADD;
        o_id_ex.rd       = rd;
        o_id_ex.pc       = i_head.pc;
        o_id_ex.pc_next  = i_head.pc + XLEN'(4);  // Link value for JAL
        o_id_ex.rs1_data = rs1_val;
        o_id_ex.rs2_data = rs2_val;
        case (opcode)
            OPC_OP: begin
                o_id_ex.alu_op = f3_to_op(funct3, alt);
                o_id_ex.wr_en  = 1'b1;
            end
            OPC_OP_IMM: begin
                // No SUBI, bit 30 only matters for SRAI
                o_id_ex.alu_op  = f3_to_op(funct3, alt && (funct3 == 3'b101));
                o_id_ex.use_imm = 1'b1;
                o_id_ex.imm     = imm_i;
                o_id_ex.wr_en   = 1'b1;
            end
            OPC_LUI: begin
                o_id_ex.alu_op  = ALU_PASS_B;
                o_id_ex.use_imm = 1'b1;
                o_id_ex.imm     = imm_u;
                o_id_ex.wr_en   = 1'b1;
            end
            OPC_AUIPC: begin
                o_id_ex.use_pc  = 1'b1;  // pc + imm_u
                o_id_ex.use_imm = 1'b1;
                o_id_ex.imm     = imm_u;
                o_id_ex.wr_en   = 1'b1;
            end
            OPC_JAL: begin
                o_id_ex.alu_op = ALU_LINK;
                o_id_ex.imm    = imm_j;  // Target offset, redirect is up to fetch
                o_id_ex.wr_en  = 1'b1;
            end
            default: ;  // No-op
        endcase
        o_id_ex.wr_en = o_id_ex.wr_en && i_head.valid && (rd != '0);  // x0 never written
    end

endmodule

`default_nettype wire

//--- instr_queue.sv
/*
 * Two-entry instruction FIFO between fetch and decode.
 * The head is presented with valid set while non-empty and pops when the pipe advances.
 * Each pop hands one credit back to the sender through o_in_credit.
 */
`timescale 1ns/10ps
`default_nettype none

module instr_queue
    import rv_exec_pkg::*;
(
    input  wire        clk,
    input  wire        i_rst,
    input  fetch_pkt_t i_push_pkt,   // Valid marks a push
    input  wire        i_pop_en,     // Pipeline advancing
    output fetch_pkt_t o_head,
    output logic       o_in_credit   // One pulse per pop
);

    typedef logic [$clog2(IN_CREDITS)-1:0] qptr_t;

    fetch_pkt_t                    mem [IN_CREDITS];  // Payload only, no reset
    qptr_t                         wr_ptr;
    qptr_t                         rd_ptr;
    logic [$clog2(IN_CREDITS):0]   count;             // 0..IN_CREDITS
    logic                          push;
    logic                          pop;

    assign push = i_push_pkt.valid;
    assign pop  = i_pop_en && (count != '0);  // Empty queue never pops

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_push_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, wraps
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Idle or push+pop
            endcase
        end
    end

    always_comb begin
        o_head       = mem[rd_ptr];
        o_head.valid = (count != '0);  // Stored valid bit is not trusted
    end

    assign o_in_credit = pop;

    // Sender only pushes while holding a credit, so a full queue is never pushed
    a_no_push_full: assert property (@(posedge clk) disable iff (i_rst)
        push |-> (count != IN_CREDITS[$clog2(IN_CREDITS):0]));

endmodule

`default_nettype wire

//--- reg_file.sv
/*
 * Architectural register file, x1..x31 with x0 tied to zero.
 * Two combinational read ports for decode, one write port from execute.
 */
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import rv_exec_pkg::*;
(
    input  wire      clk,
    input  wire      i_rst,
    input  reg_idx_t i_rs1_idx,
    input  reg_idx_t i_rs2_idx,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data,
    input  wire      i_wr_en,
    input  reg_idx_t i_wr_idx,
    input  word_t    i_wr_data
);

    word_t regs [31:1];  // No storage behind x0

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_idx != '0)) begin  // x0 writes dropped
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    // Same-cycle write is not visible here, decode forwards from EX instead
    assign o_rs1_data = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
    assign o_rs2_data = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the rv_exec_core testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module rv_exec_core_tb \
    -Mdir "$OBJ" \
    -f rv_exec_core.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$OBJ/Vrv_exec_core_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- rv_exec_core.f
rv_exec_pkg.sv
instr_queue.sv
reg_file.sv
instr_decoder.sv
id_ex_reg.sv
exec_stage.sv
rv_exec_core.sv
rv_exec_core_tb.sv

//--- rv_exec_core.sv
/*
 * Top of the decode-to-execute slice.
 * Fetch packets enter under input credits, results leave under output credits.
 * The EX stall freezes the ID/EX register and the queue pop together.
 */
`timescale 1ns/10ps
`default_nettype none

module rv_exec_core
    import rv_exec_pkg::*;
(
    input  wire        clk,
    input  wire        i_rst,
    input  fetch_pkt_t i_fetch,
    output logic       o_in_credit,
    output result_t    o_result,
    input  wire        i_res_credit
);

    fetch_pkt_t head;
    id_ex_t     id_ex_d;        // Decode output
    id_ex_t     id_ex_q;        // EX input
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       fwd_en;
    reg_idx_t   fwd_rd;
    word_t      fwd_value;
    logic       wr_en;
    reg_idx_t   wr_idx;
    word_t      wr_data;
    logic       stall;
    logic       advance;

    assign advance = !stall;  // Pop and ID/EX load move together

    instr_queue u_queue (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_push_pkt  (i_fetch),
        .i_pop_en    (advance),
        .o_head      (head),
        .o_in_credit (o_in_credit)
    );

    reg_file u_regs (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_rs1_idx  (rs1_idx),
        .i_rs2_idx  (rs2_idx),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wr_en    (wr_en),
        .i_wr_idx   (wr_idx),
        .i_wr_data  (wr_data)
    );

    instr_decoder u_dec (
        .i_head      (head),
        .o_rs1_idx   (rs1_idx),
        .o_rs2_idx   (rs2_idx),
        .i_rs1_data  (rs1_data),
        .i_rs2_data  (rs2_data),
        .i_fwd_en    (fwd_en),
        .i_fwd_rd    (fwd_rd),
        .i_fwd_value (fwd_value),
        .o_id_ex     (id_ex_d)
    );

    id_ex_reg u_id_ex (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_en    (advance),
        .i_id_ex (id_ex_d),
        .o_id_ex (id_ex_q)
    );

    exec_stage u_ex (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_id_ex      (id_ex_q),
        .i_res_credit (i_res_credit),
        .o_stall      (stall),
        .o_fwd_en     (fwd_en),
        .o_fwd_rd     (fwd_rd),
        .o_fwd_value  (fwd_value),
        .o_wr_en      (wr_en),
        .o_wr_idx     (wr_idx),
        .o_wr_data    (wr_data),
        .o_result     (o_result)
    );

endmodule

`default_nettype wire

//--- rv_exec_core_tb.sv
/*
 * Testbench for the RV32I decode-to-execute slice.
 * Sends a seeded random instruction stream under input credits and runs a reference model.
 * A random consumer with long pauses drains results and returns output credits.
 */
`timescale 1ns/10ps
`default_nettype none

module rv_exec_core_tb
    import rv_exec_pkg::*;
;

    localparam int          NUM_INSTR = 400;
    localparam int          TIMEOUT   = 40 * NUM_INSTR;  // Cycles, generous for pauses
    localparam int unsigned SEED      = 32'h32406709;

    logic       clk;
    logic       i_rst        = 1'b1;
    fetch_pkt_t i_fetch      = '0;
    logic       i_res_credit = 1'b0;
    logic       o_in_credit;
    result_t    o_result;

    word_t       model_regs [32] = '{default: '0};  // Reference register state
    result_t     exp_q [$];                          // Expected results in program order
    credit_cnt_t in_credits = credit_cnt_t'(IN_CREDITS);
    credit_cnt_t buf_cnt    = '0;                    // Results held by the consumer
    int          sent_cnt   = 0;
    int          exp_cnt    = 0;
    int          recv_cnt   = 0;
    int          pause_left = 0;
    int          cycle_cnt  = 0;

    rv_exec_core DUT (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_fetch      (i_fetch),
        .o_in_credit  (o_in_credit),
        .o_result     (o_result),
        .i_res_credit (i_res_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic check_result(input string name, input result_t exp, input result_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s: expected pc=%h rd=%0d value=%h, %s",
                               name, exp.pc, exp.rd, exp.value,
                               $sformatf("actual pc=%h rd=%0d value=%h",
                                         act.pc, act.rd, act.value)));
        end
    endtask

    task automatic check_credit_count(input string name, input credit_cnt_t count,
                                      input credit_cnt_t limit);
        if (count > limit) begin
            fail_run($sformatf("%s holds %0d credits, more than the limit of %0d",
                               name, count, limit));
        end
    endtask

    // RV32I ALU semantics by funct3 and the funct7 alternate bit
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Builds one random instruction and runs it through the model
    task automatic gen_instr(output fetch_pkt_t pkt);
        int          kind;
        logic [2:0]  f3;
        logic        alt;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [11:0] imm12;
        logic [19:0] imm20;
        word_t       pc;
        word_t       value;
        instr_t      instr;
        logic        writes;
        kind   = $urandom_range(0, 18);
        f3     = 3'($urandom_range(0, 7));
        alt    = 1'($urandom_range(0, 1));
        rd     = reg_idx_t'($urandom_range(0, 7));   // Small set, lots of dependencies
        rs1    = reg_idx_t'($urandom_range(0, 7));
        rs2    = reg_idx_t'($urandom_range(0, 7));
        imm12  = 12'($urandom);
        imm20  = 20'($urandom);
        pc     = word_t'($urandom) & ~word_t'(3);
        writes = 1'b1;
        value  = '0;
        if (kind < 8) begin                            // Register-register
            if (f3 != 3'b000 && f3 != 3'b101) alt = 1'b0;
            instr = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OPC_OP};
            value = alu_model(f3, alt, model_regs[rs1], model_regs[rs2]);
        end else if (kind < 15) begin                  // Register-immediate
            if (f3 == 3'b101) begin
                imm12 = {alt ? 7'b0100000 : 7'b0000000, imm12[4:0]};
            end else if (f3 == 3'b001) begin
                alt   = 1'b0;
                imm12 = {7'b0000000, imm12[4:0]};
            end else begin
                alt = 1'b0;                            // No SUBI
            end
            instr = {imm12, rs1, f3, rd, OPC_OP_IMM};
            value = alu_model(f3, alt, model_regs[rs1], {{20{imm12[11]}}, imm12});
        end else if (kind == 15) begin
            instr = {imm20, rd, OPC_LUI};
            value = {imm20, 12'b0};
        end else if (kind == 16) begin
            instr = {imm20, rd, OPC_AUIPC};
            value = pc + {imm20, 12'b0};
        end else if (kind == 17) begin
            instr = {imm20, rd, OPC_JAL};
            value = pc + word_t'(4);                   // Link address only
        end else begin                                 // Store word, executes as no-op
            instr  = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], 7'b0100011};
            writes = 1'b0;
        end
        if (writes && rd != '0) begin                  // x0 writes are never reported
            model_regs[rd] = value;
            exp_q.push_back('{valid: 1'b1, pc: pc, rd: rd, value: value});
            exp_cnt++;
        end
        pkt = '{valid: 1'b1, pc: pc, instr: instr};
    endtask

    // Sender, spends one credit per valid cycle
    always @(posedge clk) begin
        fetch_pkt_t pkt;
        if (i_rst) begin
            i_fetch <= '0;
        end else begin
            if (o_in_credit) in_credits = in_credits + 1'b1;
            check_credit_count("sender", in_credits, credit_cnt_t'(IN_CREDITS));
            if (sent_cnt < NUM_INSTR && in_credits != '0 && $urandom_range(0, 2) != 0) begin
                gen_instr(pkt);
                i_fetch    <= pkt;
                in_credits = in_credits - 1'b1;
                sent_cnt++;
            end else begin
                i_fetch <= '0;
            end
        end
    end

    // Consumer, takes results and drains its buffer with random pauses
    always @(posedge clk) begin
        result_t exp;
        if (i_rst) begin
            i_res_credit <= 1'b0;
        end else begin
            if (o_result.valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("result reported with no instruction left to match it");
                end else begin
                    exp = exp_q.pop_front();
                    check_result($sformatf("result %0d", recv_cnt), exp, o_result);
                    recv_cnt++;
                    buf_cnt = buf_cnt + 1'b1;
                    check_credit_count("consumer buffer", buf_cnt,
                                       credit_cnt_t'(OUT_CREDITS));
                end
            end
            if (pause_left != 0) begin
                pause_left--;
            end else if ($urandom_range(0, 39) == 0) begin
                pause_left = $urandom_range(10, 40);   // Long stall, fills the credits
            end
            if (pause_left == 0 && buf_cnt != '0 && $urandom_range(0, 1) != 0) begin
                i_res_credit <= 1'b1;
                buf_cnt      = buf_cnt - 1'b1;
            end else begin
                i_res_credit <= 1'b0;
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            fail_run($sformatf("timeout after %0d cycles with %0d of %0d results received",
                               cycle_cnt, recv_cnt, exp_cnt));
        end
    end

    initial begin
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        i_rst <= 1'b0;
        while (!(sent_cnt == NUM_INSTR && exp_q.size() == 0)) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);  // Quiet window, a stray result fails in the consumer
        if (exp_q.size() == 0 && recv_cnt == exp_cnt &&
            in_credits == credit_cnt_t'(IN_CREDITS)) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_run($sformatf("end of run with %0d results missing or %0d input credits held",
                               exp_q.size(), in_credits));
        end
    end

endmodule

`default_nettype wire

//--- rv_exec_pkg.sv
/*
 * Shared definitions for the RV32I decode-to-execute slice.
 * Holds widths, opcodes, the ALU operation set, the stage bundles and credit depths.
 * Every design file pulls this in with a wildcard import in its module header.
 */
`default_nettype none

package rv_exec_pkg;

    localparam int unsigned XLEN        = 32;  // Data path width
    localparam int unsigned IN_CREDITS  = 2;   // Input queue depth, sender start credits
    localparam int unsigned OUT_CREDITS = 4;   // Consumer buffer depth

    // Major opcodes handled by the slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Reg-reg ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Reg-imm ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;  // Link only, fetch redirects

    typedef logic [XLEN-1:0] word_t;     // Data or address
    typedef logic [31:0]     instr_t;    // Raw instruction
    typedef logic [4:0]      reg_idx_t;  // Architectural register number
    typedef logic [2:0]      credit_cnt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B,  // LUI, operand B straight through
        ALU_LINK     // JAL, result is pc+4
    } alu_op_e;

    // Fetch to queue
    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_t instr;
    } fetch_pkt_t;

    // Decode to execute
    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        logic     use_imm;   // Operand B from imm
        logic     use_pc;    // Operand A from pc
        logic     wr_en;     // Writes rd, never set for x0
        reg_idx_t rd;
        word_t    pc;
        word_t    pc_next;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
    } id_ex_t;

    // Reported write-back, only writing instructions show up here
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
    } result_t;

endpackage

`default_nettype wire
